//--- Bender.yml
package:
  name: csc

sources:
  - rtl/csc_pkg.sv
  - rtl/chroma_upsampler.sv
  - rtl/rgb_convert.sv
  - rtl/csc_sequencer.sv
  - rtl/csc_top.sv
  - target: simulation
    files:
      - dv/sram_model.sv
      - dv/csc_asserts.sv
      - dv/csc_tb.sv

//--- dv/csc_asserts.sv
module csc_asserts (
	input logic CLOCK_50_I,
	input logic Resetn,
	input csc_pkg::seq_state_t state,
	input csc_pkg::sram_addr_t address,
	input logic write_en_n,
	input logic finish
);
	import csc_pkg::*;

	int failures = 0;

	// the RGB plane reaches the top of the address space
	write_in_rgb_plane: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		!write_en_n |-> address >= RGB_BASE)
		else begin
			failures++;
			$error("SRAM write below the RGB plane at address %0d", address);
		end

	no_write_when_idle: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		state == st_idle |-> write_en_n)
		else begin
			failures++;
			$error("SRAM write while the sequencer is idle");
		end

	no_write_after_finish: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		finish |-> write_en_n)
		else begin
			failures++;
			$error("SRAM write while finish is high");
		end

endmodule

bind csc_sequencer csc_asserts asserts0 (
	.CLOCK_50_I(CLOCK_50_I),
	.Resetn(Resetn),
	.state(state),
	.address(address),
	.write_en_n(write_en_n),
	.finish(finish)
);

//--- dv/csc_tb.sv
module csc_tb;
	import csc_pkg::*;

	localparam int FRAME_WORDS = FRAME_ROWS * CHROMA_WIDTH * 3;
	localparam int FINISH_TIMEOUT = 600000;
	localparam int FORCED_COUNT = 5;

	logic CLOCK_50_I;
	logic Resetn;
	logic start;
	sram_word_t sram_read_data;
	sram_addr_t address;
	sram_word_t write_data;
	logic write_en_n;
	logic finish;

	integer seed;
	int errors;
	int word_idx;
	pixel_t y_pix [FRAME_ROWS * FRAME_WIDTH];
	pixel_t u_pix [FRAME_ROWS * CHROMA_WIDTH];
	pixel_t v_pix [FRAME_ROWS * CHROMA_WIDTH];
	// even pixels set to Y = V = 255 or Y = V = 0, some on row edges
	int forced_row [FORCED_COUNT] = '{0, 0, 120, 239, 239};
	int forced_k [FORCED_COUNT] = '{0, 159, 37, 159, 0};
	bit forced_hi [FORCED_COUNT] = '{1, 0, 1, 0, 1};

	csc_top dut0 (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.start(start),
		.sram_read_data(sram_read_data),
		.address(address),
		.write_data(write_data),
		.write_en_n(write_en_n),
		.finish(finish)
	);

	sram_model sram0 (
		.CLOCK_50_I(CLOCK_50_I),
		.address(address),
		.write_data(write_data),
		.write_en_n(write_en_n),
		.read_data(sram_read_data)
	);

	initial begin
		CLOCK_50_I = 1'b0;
		forever #10 CLOCK_50_I = ~CLOCK_50_I;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		errors++;
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_word(input sram_word_t got, input sram_word_t exp, input string name);
		if (got !== exp) begin
			abort_run($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_addr(input sram_addr_t got, input sram_addr_t exp, input string name);
		if (got !== exp) begin
			abort_run($sformatf("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			abort_run($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
		end
	endtask

	function automatic pixel_t clamp_byte(input int value);
		if (value < 0) begin
			return 8'd0;
		end
		if (value > 255) begin
			return 8'd255;
		end
		return pixel_t'(value);
	endfunction

	// chroma sample with the column clamped to the row
	function automatic int chroma_at(input bit is_v, input int row, input int idx);
		int col;
		col = idx < 0 ? 0 : (idx > CHROMA_WIDTH - 1 ? CHROMA_WIDTH - 1 : idx);
		if (is_v) begin
			return v_pix[row * CHROMA_WIDTH + col];
		end
		return u_pix[row * CHROMA_WIDTH + col];
	endfunction

	// interpolated chroma for the odd pixel of pair k
	function automatic pixel_t odd_chroma(input bit is_v, input int row, input int k);
		int acc;
		acc = FIR_TAP0 * (chroma_at(is_v, row, k - 2) + chroma_at(is_v, row, k + 3))
			+ FIR_TAP1 * (chroma_at(is_v, row, k - 1) + chroma_at(is_v, row, k + 2))
			+ FIR_TAP2 * (chroma_at(is_v, row, k) + chroma_at(is_v, row, k + 1))
			+ FIR_ROUND;
		return clamp_byte(acc >>> FIR_SHIFT);
	endfunction

	function automatic void convert_pixel(input int y, input int u, input int v,
		output pixel_t r, output pixel_t g, output pixel_t b);
		int luma;
		luma = K_Y * (y - Y_OFFSET);
		r = clamp_byte((luma + K_RV * (v - C_OFFSET)) >>> MATRIX_SHIFT);
		g = clamp_byte((luma + K_GU * (u - C_OFFSET) + K_GV * (v - C_OFFSET)) >>> MATRIX_SHIFT);
		b = clamp_byte((luma + K_BU * (u - C_OFFSET)) >>> MATRIX_SHIFT);
	endfunction

	function automatic sram_word_t ref_rgb(input int row, input int k, input int slot);
		pixel_t r0, g0, b0, r1, g1, b1;
		int y0;
		int y1;
		y0 = y_pix[row * FRAME_WIDTH + 2 * k];
		y1 = y_pix[row * FRAME_WIDTH + 2 * k + 1];
		convert_pixel(y0, chroma_at(1'b0, row, k), chroma_at(1'b1, row, k), r0, g0, b0);
		convert_pixel(y1, odd_chroma(1'b0, row, k), odd_chroma(1'b1, row, k), r1, g1, b1);
		case (slot)
			0: return {r0, g0};
			1: return {b0, r1};
			default: return {g1, b1};
		endcase
	endfunction

	task automatic load_frame();
		int idx;
		int pix;
		for (idx = 0; idx < FRAME_ROWS * FRAME_WIDTH; idx++) begin
			y_pix[idx] = pixel_t'($random(seed));
		end
		for (idx = 0; idx < FRAME_ROWS * CHROMA_WIDTH; idx++) begin
			u_pix[idx] = pixel_t'($random(seed));
			v_pix[idx] = pixel_t'($random(seed));
		end
		for (idx = 0; idx < FORCED_COUNT; idx++) begin
			pix = forced_hi[idx] ? 255 : 0;
			y_pix[forced_row[idx] * FRAME_WIDTH + 2 * forced_k[idx]] = pixel_t'(pix);
			v_pix[forced_row[idx] * CHROMA_WIDTH + forced_k[idx]] = pixel_t'(pix);
		end
		// planes are row after row, two samples per word
		for (idx = 0; idx < FRAME_ROWS * FRAME_WIDTH / 2; idx++) begin
			sram0.mem[Y_BASE + idx] = {y_pix[2 * idx], y_pix[2 * idx + 1]};
		end
		for (idx = 0; idx < FRAME_ROWS * CHROMA_WIDTH / 2; idx++) begin
			sram0.mem[U_BASE + idx] = {u_pix[2 * idx], u_pix[2 * idx + 1]};
			sram0.mem[V_BASE + idx] = {v_pix[2 * idx], v_pix[2 * idx + 1]};
		end
	endtask

	task automatic compare_write();
		int pair;
		sram_word_t expected;
		if (word_idx >= FRAME_WORDS) begin
			abort_run("an SRAM write was seen after the last RGB word of the frame");
		end else begin
			pair = word_idx / 3;
			expected = ref_rgb(pair / CHROMA_WIDTH, pair % CHROMA_WIDTH, word_idx % 3);
			check_bit(finish, 1'b0, "finish");
			check_addr(address, RGB_BASE + sram_addr_t'(word_idx), "address");
			check_word(write_data, expected, "write_data");
			word_idx++;
		end
	endtask

	// mid-cycle sampling of the write port
	always @(negedge CLOCK_50_I) begin
		if (Resetn === 1'b1) begin
			if (dut0.seq0.asserts0.failures != 0) begin
				abort_run("a bound SRAM protocol assertion failed");
			end else if (write_en_n !== 1'b1) begin
				compare_write();
			end
		end
	end

	initial begin
		int cycles;
		int frame;
		int idx;
		int w;
		seed = 32'h779b;
		errors = 0;
		word_idx = 0;
		start = 1'b0;
		Resetn = 1'b0;
		load_frame();
		repeat (3) @(posedge CLOCK_50_I);
		#2 Resetn = 1'b1;
		repeat (4) begin
			@(negedge CLOCK_50_I);
			check_bit(write_en_n, 1'b1, "write_en_n");
			check_bit(finish, 1'b0, "finish");
		end
		for (frame = 0; frame < 2; frame++) begin
			@(posedge CLOCK_50_I);
			#2;
			word_idx = 0;
			start = 1'b1;
			@(posedge CLOCK_50_I);
			#2 start = 1'b0;
			cycles = 0;
			while (finish !== 1'b1 && cycles < FINISH_TIMEOUT) begin
				@(negedge CLOCK_50_I);
				cycles++;
			end
			if (finish !== 1'b1) begin
				abort_run("timeout while waiting for finish");
			end else if (word_idx != FRAME_WORDS) begin
				abort_run($sformatf("finish rose after %0d of %0d RGB writes", word_idx,
					FRAME_WORDS));
			end
			// the frame must stay quiet once finish is up
			repeat (50) begin
				@(negedge CLOCK_50_I);
				check_bit(finish, 1'b1, "finish");
			end
		end
		for (idx = 0; idx < FORCED_COUNT; idx++) begin
			w = (forced_row[idx] * CHROMA_WIDTH + forced_k[idx]) * 3;
			check_word(sram0.mem[RGB_BASE + w] & 16'hff00, forced_hi[idx] ? 16'hff00 : 16'h0000,
				"forced pixel R0");
		end
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- dv/sram_model.sv
module sram_model (
	input logic CLOCK_50_I,
	input csc_pkg::sram_addr_t address,
	input csc_pkg::sram_word_t write_data,
	input logic write_en_n,
	output csc_pkg::sram_word_t read_data
);
	import csc_pkg::*;

	sram_word_t mem [0:2**18-1];
	// first stage of the two-cycle read path
	sram_word_t read_stage;

	always @(posedge CLOCK_50_I) begin
		if (!write_en_n) begin
			mem[address] <= write_data;
		end
	end

	// a read of the address being written returns the old word
	always_ff @(posedge CLOCK_50_I) begin
		read_stage <= mem[address];
		read_data <= read_stage;
	end

endmodule

//--- files.f
rtl/csc_pkg.sv
rtl/chroma_upsampler.sv
rtl/rgb_convert.sv
rtl/csc_sequencer.sv
rtl/csc_top.sv
dv/sram_model.sv
dv/csc_asserts.sv
dv/csc_tb.sv

//--- rtl/chroma_upsampler.sv
module chroma_upsampler (
	input logic CLOCK_50_I,
	input logic Resetn,
	input csc_pkg::sram_word_t chroma_word,
	input logic u_load,
	input logic v_load,
	input logic row_start,
	input logic filter_go,
	output csc_pkg::pixel_t u_even,
	output csc_pkg::pixel_t v_even,
	output csc_pkg::pixel_t u_odd,
	output csc_pkg::pixel_t v_odd,
	output logic chroma_ready
);
	import csc_pkg::*;

	// index 0 is U, index 1 is V; entry 2 is sample k of the current pair
	pixel_t win [2][6];
	logic [1:0] load;
	logic v_phase;
	acc_t prod0;
	acc_t prod1;
	acc_t prod2;
	pixel_t fir_out;

	assign load = {v_load, u_load};

	// U on the filter_go cycle, V on the cycle after
	assign prod0 = FIR_TAP0 * (acc_t'(win[v_phase][0]) + acc_t'(win[v_phase][5]));
	assign prod1 = FIR_TAP1 * (acc_t'(win[v_phase][1]) + acc_t'(win[v_phase][4]));
	assign prod2 = FIR_TAP2 * (acc_t'(win[v_phase][2]) + acc_t'(win[v_phase][3]));
	assign fir_out = clip_pixel((prod0 + prod1 + prod2 + FIR_ROUND) >>> FIR_SHIFT);

	always_ff @(posedge CLOCK_50_I) begin
		for (int c = 0; c < 2; c++) begin
			if (load[c]) begin
				if (row_start) begin
					// replicate sample 0 over the left edge
					for (int i = 0; i < 6; i++) begin
						win[c][i] <= chroma_word[15:8];
					end
				end else begin
					for (int i = 0; i < 5; i++) begin
						win[c][i] <= win[c][i + 1];
					end
					win[c][5] <= chroma_word[15:8];
				end
			end
		end
		if (filter_go) begin
			u_odd <= fir_out;
		end
		if (v_phase) begin
			v_odd <= fir_out;
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (~Resetn) begin
			v_phase <= 1'b0;
			chroma_ready <= 1'b0;
		end else begin
			v_phase <= filter_go;
			if (filter_go || row_start) begin
				chroma_ready <= 1'b0;
			end else if (v_phase) begin
				chroma_ready <= 1'b1;
			end
		end
	end

	assign u_even = win[0][2];
	assign v_even = win[1][2];

endmodule

//--- rtl/csc_pkg.sv
package csc_pkg;

	typedef logic [17:0] sram_addr_t;
	// high byte carries the even pixel or sample
	typedef logic [15:0] sram_word_t;
	typedef logic [7:0] pixel_t;
	typedef logic signed [31:0] acc_t;

	typedef enum logic [2:0] {
		st_idle,
		// fills the chroma windows for a new row
		st_row_lead_in,
		st_pair_read,
		st_pair_filter,
		st_pair_write,
		st_row_end,
		st_done
	} seq_state_t;

	localparam int FRAME_WIDTH = 320;
	localparam int FRAME_ROWS = 240;
	localparam int CHROMA_WIDTH = FRAME_WIDTH / 2;

	// word addresses in the SRAM
	localparam sram_addr_t Y_BASE = 18'd0;
	localparam sram_addr_t U_BASE = 18'd38400;
	localparam sram_addr_t V_BASE = 18'd57600;
	localparam sram_addr_t RGB_BASE = 18'd146944;
	localparam int SRAM_READ_LATENCY = 2;

	// odd-sample interpolation filter, symmetric six taps
	localparam acc_t FIR_TAP0 = 32'sd21;
	localparam acc_t FIR_TAP1 = -32'sd52;
	localparam acc_t FIR_TAP2 = 32'sd159;
	localparam acc_t FIR_ROUND = 32'sd128;
	localparam int FIR_SHIFT = 8;

	// colour matrix in 16.16 fixed point
	localparam acc_t K_Y = 32'sd76284;
	localparam acc_t K_RV = 32'sd104595;
	localparam acc_t K_GU = -32'sd25624;
	localparam acc_t K_GV = -32'sd53281;
	localparam acc_t K_BU = 32'sd132251;
	localparam acc_t Y_OFFSET = 32'sd16;
	localparam acc_t C_OFFSET = 32'sd128;
	localparam int MATRIX_SHIFT = 16;

	// saturate a signed result to one 8-bit channel
	function automatic pixel_t clip_pixel(input acc_t value);
		if (value < 0) begin
			return 8'd0;
		end
		if (value > 32'sd255) begin
			return 8'd255;
		end
		return value[7:0];
	endfunction

endpackage

//--- rtl/csc_sequencer.sv
module csc_sequencer (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start,
	input csc_pkg::sram_word_t sram_read_data,
	input csc_pkg::sram_word_t rgb_word,
	input logic rgb_valid,
	output csc_pkg::sram_addr_t address,
	output csc_pkg::sram_word_t write_data,
	output logic write_en_n,
	output logic finish,
	output csc_pkg::sram_word_t chroma_word,
	output logic u_load,
	output logic v_load,
	output logic row_start,
	output logic filter_go,
	output csc_pkg::sram_word_t y_word,
	output logic pair_go
);
	import csc_pkg::*;

	seq_state_t state;
	logic [3:0] step;
	logic [7:0] pair_cnt;
	logic [7:0] row_cnt;
	sram_addr_t y_addr;
	sram_addr_t u_addr;
	sram_addr_t v_addr;
	sram_addr_t rgb_addr;
	logic iss_y;
	logic iss_u;
	logic iss_v;
	logic iss_held;
	logic iss_first;
	logic need_chroma;
	logic last_pair;
	logic ret_held;
	pixel_t u_lo;
	pixel_t v_lo;
	// one bit per read in flight, aligned with the SRAM latency
	logic [SRAM_READ_LATENCY-1:0] tag_y;
	logic [SRAM_READ_LATENCY-1:0] tag_u;
	logic [SRAM_READ_LATENCY-1:0] tag_v;
	logic [SRAM_READ_LATENCY-1:0] tag_held;
	logic [SRAM_READ_LATENCY-1:0] tag_first;

	assign last_pair = pair_cnt == 8'(CHROMA_WIDTH - 1);
	// sample k+4 comes from a new word on even pairs until word 79 is in
	assign need_chroma = ~pair_cnt[0] && (pair_cnt < 8'(CHROMA_WIDTH - 5));

	assign filter_go = (state == st_pair_filter) && (step == 4'd0);
	assign pair_go = (state == st_pair_filter) && (step == 4'd2);

	always_comb begin
		iss_y = 1'b0;
		iss_u = 1'b0;
		iss_v = 1'b0;
		iss_held = 1'b0;
		iss_first = 1'b0;
		case (state)
			st_row_lead_in: begin
				// U words 0,1 then V words 0,1, each followed by its low byte
				if (step == 4'd8) begin
					iss_y = 1'b1;
				end else if (step < 4'd8) begin
					iss_u = ~step[2];
					iss_v = step[2];
					iss_held = step[0];
					iss_first = step[1:0] == 2'd0;
				end
			end
			st_pair_filter: iss_y = pair_go && !last_pair;
			st_pair_read: begin
				iss_u = step == 4'd0;
				iss_v = step == 4'd1;
				iss_held = ~need_chroma;
			end
			default: ;
		endcase
	end

	// writes win the port, reads are scheduled around them
	always_comb begin
		if (rgb_valid) begin
			address = rgb_addr;
		end else if (iss_y) begin
			address = y_addr;
		end else if (iss_u) begin
			address = u_addr;
		end else begin
			address = v_addr;
		end
	end

	assign write_en_n = ~rgb_valid;
	assign write_data = rgb_word;

	assign u_load = tag_u[SRAM_READ_LATENCY-1];
	assign v_load = tag_v[SRAM_READ_LATENCY-1];
	assign row_start = tag_first[SRAM_READ_LATENCY-1];
	assign ret_held = tag_held[SRAM_READ_LATENCY-1];

	// held returns replay the low byte of the last word fetched
	always_comb begin
		if (!ret_held) begin
			chroma_word = sram_read_data;
		end else if (u_load) begin
			chroma_word = {u_lo, 8'h00};
		end else begin
			chroma_word = {v_lo, 8'h00};
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (tag_y[SRAM_READ_LATENCY-1]) begin
			y_word <= sram_read_data;
		end
		if (u_load && !ret_held) begin
			u_lo <= sram_read_data[7:0];
		end
		if (v_load && !ret_held) begin
			v_lo <= sram_read_data[7:0];
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (~Resetn) begin
			state <= st_idle;
			step <= 4'd0;
			pair_cnt <= 8'd0;
			row_cnt <= 8'd0;
			y_addr <= Y_BASE;
			u_addr <= U_BASE;
			v_addr <= V_BASE;
			rgb_addr <= RGB_BASE;
			finish <= 1'b0;
			tag_y <= '0;
			tag_u <= '0;
			tag_v <= '0;
			tag_held <= '0;
			tag_first <= '0;
		end else begin
			tag_y <= {tag_y[SRAM_READ_LATENCY-2:0], iss_y};
			tag_u <= {tag_u[SRAM_READ_LATENCY-2:0], iss_u};
			tag_v <= {tag_v[SRAM_READ_LATENCY-2:0], iss_v};
			tag_held <= {tag_held[SRAM_READ_LATENCY-2:0], iss_held};
			tag_first <= {tag_first[SRAM_READ_LATENCY-2:0], iss_first};
			if (iss_y) begin
				y_addr <= y_addr + 18'd1;
			end
			if (iss_u && !iss_held) begin
				u_addr <= u_addr + 18'd1;
			end
			if (iss_v && !iss_held) begin
				v_addr <= v_addr + 18'd1;
			end
			if (rgb_valid) begin
				rgb_addr <= rgb_addr + 18'd1;
			end
			step <= step + 4'd1;
			case (state)
				st_idle: begin
					if (start) begin
						finish <= 1'b0;
						row_cnt <= 8'd0;
						pair_cnt <= 8'd0;
						y_addr <= Y_BASE;
						u_addr <= U_BASE;
						v_addr <= V_BASE;
						rgb_addr <= RGB_BASE;
						step <= 4'd0;
						state <= st_row_lead_in;
					end
				end
				st_row_lead_in: begin
					if (step == 4'd9) begin
						step <= 4'd0;
						state <= st_pair_filter;
					end
				end
				st_pair_filter: begin
					if (pair_go) begin
						step <= 4'd0;
						state <= st_pair_read;
					end
				end
				st_pair_read: begin
					if (step == 4'd1) begin
						step <= 4'd0;
						state <= st_pair_write;
					end
				end
				// window shifts land here, the next filter follows
				st_pair_write: begin
					if (step == 4'd1) begin
						step <= 4'd0;
						if (last_pair) begin
							state <= st_row_end;
						end else begin
							pair_cnt <= pair_cnt + 8'd1;
							state <= st_pair_filter;
						end
					end
				end
				st_row_end: begin
					// wait out the last word of the row
					if (!rgb_valid) begin
						step <= 4'd0;
						pair_cnt <= 8'd0;
						if (row_cnt == 8'(FRAME_ROWS - 1)) begin
							finish <= 1'b1;
							state <= st_done;
						end else begin
							row_cnt <= row_cnt + 8'd1;
							state <= st_row_lead_in;
						end
					end
				end
				st_done: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

endmodule

//--- rtl/csc_top.sv
module csc_top (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start,
	input csc_pkg::sram_word_t sram_read_data,
	output csc_pkg::sram_addr_t address,
	output csc_pkg::sram_word_t write_data,
	output logic write_en_n,
	output logic finish
);
	import csc_pkg::*;

	sram_word_t chroma_word;
	sram_word_t y_word;
	sram_word_t rgb_word;
	logic u_load;
	logic v_load;
	logic row_start;
	logic filter_go;
	logic pair_go;
	logic rgb_valid;
	logic chroma_ready;
	pixel_t u_even;
	pixel_t v_even;
	pixel_t u_odd;
	pixel_t v_odd;

	csc_sequencer seq0 (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.start(start),
		.sram_read_data(sram_read_data),
		.rgb_word(rgb_word),
		.rgb_valid(rgb_valid),
		.address(address),
		.write_data(write_data),
		.write_en_n(write_en_n),
		.finish(finish),
		.chroma_word(chroma_word),
		.u_load(u_load),
		.v_load(v_load),
		.row_start(row_start),
		.filter_go(filter_go),
		.y_word(y_word),
		.pair_go(pair_go)
	);

	chroma_upsampler ups0 (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.chroma_word(chroma_word),
		.u_load(u_load),
		.v_load(v_load),
		.row_start(row_start),
		.filter_go(filter_go),
		.u_even(u_even),
		.v_even(v_even),
		.u_odd(u_odd),
		.v_odd(v_odd),
		.chroma_ready(chroma_ready)
	);

	rgb_convert cnv0 (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.pair_go(pair_go),
		.chroma_ready(chroma_ready),
		.y_word(y_word),
		.u_even(u_even),
		.v_even(v_even),
		.u_odd(u_odd),
		.v_odd(v_odd),
		.rgb_word(rgb_word),
		.rgb_valid(rgb_valid)
	);

endmodule

//--- rtl/rgb_convert.sv
module rgb_convert (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic pair_go,
	input logic chroma_ready,
	input csc_pkg::sram_word_t y_word,
	input csc_pkg::pixel_t u_even,
	input csc_pkg::pixel_t v_even,
	input csc_pkg::pixel_t u_odd,
	input csc_pkg::pixel_t v_odd,
	output csc_pkg::sram_word_t rgb_word,
	output logic rgb_valid
);
	import csc_pkg::*;

	// 0 idle, 1..4 multiplier passes
	logic [2:0] phase;
	logic launch;
	pixel_t y0_q, y1_q, ue_q, ve_q, uo_q, vo_q;
	pixel_t b0_q;
	acc_t op0, op1, op2;
	acc_t k0, k1, k2;
	acc_t m0, m1, m2;
	acc_t y_prod;
	acc_t c_prod_a;
	acc_t c_prod_b;

	function automatic acc_t centered(input pixel_t sample, input acc_t offset);
		return acc_t'(sample) - offset;
	endfunction

	assign launch = pair_go && chroma_ready;

	always_comb begin
		op0 = '0;
		op1 = '0;
		op2 = '0;
		k0 = '0;
		k1 = '0;
		k2 = '0;
		case (phase)
			3'd1: begin
				op0 = centered(y0_q, Y_OFFSET);
				k0 = K_Y;
				op1 = centered(ve_q, C_OFFSET);
				k1 = K_RV;
				op2 = centered(ue_q, C_OFFSET);
				k2 = K_GU;
			end
			3'd2: begin
				op0 = centered(ve_q, C_OFFSET);
				k0 = K_GV;
				op1 = centered(ue_q, C_OFFSET);
				k1 = K_BU;
				op2 = centered(y1_q, Y_OFFSET);
				k2 = K_Y;
			end
			3'd3: begin
				op0 = centered(vo_q, C_OFFSET);
				k0 = K_RV;
				op1 = centered(uo_q, C_OFFSET);
				k1 = K_GU;
				op2 = centered(vo_q, C_OFFSET);
				k2 = K_GV;
			end
			3'd4: begin
				op0 = centered(uo_q, C_OFFSET);
				k0 = K_BU;
			end
			default: ;
		endcase
	end

	assign m0 = op0 * k0;
	assign m1 = op1 * k1;
	assign m2 = op2 * k2;

	always_ff @(posedge CLOCK_50_I) begin
		if (launch) begin
			y0_q <= y_word[15:8];
			y1_q <= y_word[7:0];
			ue_q <= u_even;
			ve_q <= v_even;
			uo_q <= u_odd;
			vo_q <= v_odd;
		end
		case (phase)
			3'd1: begin
				y_prod <= m0;
				c_prod_a <= m1;
				c_prod_b <= m2;
			end
			3'd2: begin
				rgb_word <= {clip_pixel((y_prod + c_prod_a) >>> MATRIX_SHIFT),
					clip_pixel((y_prod + c_prod_b + m0) >>> MATRIX_SHIFT)};
				b0_q <= clip_pixel((y_prod + m1) >>> MATRIX_SHIFT);
				// odd pixel luma takes over the Y product
				y_prod <= m2;
			end
			3'd3: begin
				rgb_word <= {b0_q, clip_pixel((y_prod + m0) >>> MATRIX_SHIFT)};
				c_prod_a <= m1;
				c_prod_b <= m2;
			end
			3'd4: begin
				rgb_word <= {clip_pixel((y_prod + c_prod_a + c_prod_b) >>> MATRIX_SHIFT),
					clip_pixel((y_prod + m0) >>> MATRIX_SHIFT)};
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (~Resetn) begin
			phase <= 3'd0;
			rgb_valid <= 1'b0;
		end else begin
			if (launch) begin
				phase <= 3'd1;
			end else if (phase == 3'd4) begin
				phase <= 3'd0;
			end else if (phase != 3'd0) begin
				phase <= phase + 3'd1;
			end
			// a word is registered in each of phases 2 to 4
			rgb_valid <= phase >= 3'd2;
		end
	end

endmodule
